/* flist.f */
+incdir+verilog
+incdir+tb
verilog/perf_pkg.sv
verilog/perf_retire_counters.sv
verilog/perf_mem_event_counters.sv
verilog/perf_apb_regs.sv
verilog/perf_unit_top.sv
tb/perf_unit_tb.sv

/* tb/perf_tb_tasks.svh */
`ifndef PERF_TB_TASKS_SVH
`define PERF_TB_TASKS_SVH

// ----------------------------------------
// APB transfers
// ----------------------------------------
// response outputs stay low outside an access cycle
task automatic check_idle_outputs();
  if (pready_o !== 1'b0) report_mismatch("pready_o", 1'b0, pready_o);
  if (pslverr_o !== 1'b0) report_mismatch("pslverr_o", 1'b0, pslverr_o);
  if (prdata_o !== '0) report_mismatch("prdata_o", '0, prdata_o);
endtask

// entered and left DRIVE_DELAY after a rising edge
task automatic apb_transfer(input logic write, input apb_addr_t addr, input counter_t wdata,
                            output counter_t rdata, output logic slverr);
  psel_i    = 1'b1;
  penable_i = 1'b0;
  pwrite_i  = write;
  paddr_i   = addr;
  pwdata_i  = wdata;
  // setup cycle gives no response yet
  #(SAMPLE_DELAY);
  check_idle_outputs();
  @(posedge clk_i);
  #(DRIVE_DELAY);
  penable_i = 1'b1;
  // access cycle with outputs settled well before the next edge
  #(SAMPLE_DELAY);
  if (pready_o !== 1'b1) report_mismatch("pready_o", 1'b1, pready_o);
  rdata  = prdata_o;
  slverr = pslverr_o;
  @(posedge clk_i);
  #(DRIVE_DELAY);
  psel_i    = 1'b0;
  penable_i = 1'b0;
  pwrite_i  = 1'b0;
endtask

task automatic apb_write(input apb_addr_t addr, input counter_t data, output logic slverr);
  counter_t unused_rdata;
  apb_transfer(1'b1, addr, data, unused_rdata, slverr);
endtask

task automatic apb_read(input apb_addr_t addr, output counter_t data, output logic slverr);
  apb_transfer(1'b0, addr, '0, data, slverr);
endtask

task automatic write_reg(input int unsigned idx, input counter_t value);
  logic slverr;
  apb_write(apb_addr_t'(idx * 4), value, slverr);
  if (slverr !== 1'b0) report_mismatch("pslverr_o", 1'b0, slverr);
  model_regs[idx] = value;
endtask

task automatic check_reg(input int unsigned idx, input counter_t expected);
  counter_t rdata;
  logic     slverr;
  apb_read(apb_addr_t'(idx * 4), rdata, slverr);
  if (slverr !== 1'b0) report_mismatch("pslverr_o", 1'b0, slverr);
  if (rdata !== expected) report_mismatch($sformatf("prdata_o reg %0d", idx), expected, rdata);
endtask

// write then read an address outside the map
task automatic check_bad_access(input apb_addr_t addr);
  counter_t value;
  counter_t rdata;
  logic     slverr;
  take_bits(32, value);
  apb_write(addr, value, slverr);
  if (slverr !== 1'b1) report_mismatch("pslverr_o", 1'b1, slverr);
  apb_read(addr, rdata, slverr);
  if (slverr !== 1'b1) report_mismatch("pslverr_o", 1'b1, slverr);
  if (rdata !== '0) report_mismatch("prdata_o", '0, rdata);
endtask

// ----------------------------------------
// directed tests
// ----------------------------------------
task automatic check_reset_state();
  check_idle_outputs();
  for (int unsigned idx = 0; idx < `PERF_NR_REGS; idx++) begin
    model_regs[idx] = '0;
    check_reg(idx, '0);
  end
endtask

task automatic write_and_readback();
  counter_t value;
  for (int unsigned idx = 2; idx < `PERF_NR_REGS; idx++) begin
    take_bits(32, value);
    write_reg(idx, value);
    check_reg(idx, value);
  end
  // word index 8, then an unaligned address inside the map
  check_bad_access(12'h020);
  check_bad_access(12'h009);
  for (int unsigned idx = 0; idx < `PERF_NR_REGS; idx++) begin
    check_reg(idx, model_regs[idx]);
  end
endtask

task automatic count_retirements();
  logic [31:0] bits;
  write_reg(IDX_INSTRET, '0);
  write_reg(IDX_EXCEPTION, '0);
  debug_mode_i = 1'b0;
  repeat (EVENT_CYCLES) begin
    take_bits(2 * `PERF_NR_COMMIT_PORTS, bits);
    commit_ack_i      = commit_vec_t'(bits);
    commit_ex_valid_i = commit_vec_t'(bits >> `PERF_NR_COMMIT_PORTS);
    for (int unsigned p = 0; p < `PERF_NR_COMMIT_PORTS; p++) begin
      if (commit_ack_i[p] && !commit_ex_valid_i[p]) model_regs[IDX_INSTRET]++;
      if (commit_ack_i[p] && commit_ex_valid_i[p]) model_regs[IDX_EXCEPTION]++;
    end
    idle_cycles(1);
  end
  debug_mode_i      = 1'b1;
  commit_ack_i      = '0;
  commit_ex_valid_i = '0;
  check_reg(IDX_INSTRET, model_regs[IDX_INSTRET]);
  check_reg(IDX_EXCEPTION, model_regs[IDX_EXCEPTION]);
endtask

// event bit k feeds register IDX_ICACHE_MISS + k
task automatic drive_mem_events(input logic [4:0] events);
  icache_miss_i = events[0];
  dcache_miss_i = events[1];
  itlb_miss_i   = events[2];
  dtlb_miss_i   = events[3];
  sb_full_i     = events[4];
endtask

task automatic count_mem_events();
  logic [31:0] bits;
  for (int unsigned idx = IDX_ICACHE_MISS; idx <= IDX_SB_FULL; idx++) begin
    write_reg(idx, '0);
  end
  debug_mode_i = 1'b0;
  repeat (EVENT_CYCLES) begin
    take_bits(5, bits);
    drive_mem_events(bits[4:0]);
    for (int unsigned k = 0; k < 5; k++) begin
      if (bits[k]) model_regs[IDX_ICACHE_MISS + k]++;
    end
    idle_cycles(1);
  end
  debug_mode_i = 1'b1;
  drive_mem_events('0);
  for (int unsigned idx = IDX_ICACHE_MISS; idx <= IDX_SB_FULL; idx++) begin
    check_reg(idx, model_regs[idx]);
  end
endtask

task automatic cycle_and_freeze();
  counter_t    value;
  counter_t    first;
  counter_t    second;
  logic        slverr;
  logic [31:0] bits;
  take_bits(32, value);
  debug_mode_i = 1'b0;
  write_reg(IDX_CYCLE, value);
  // read access starts two edges after the write lands
  idle_cycles(1);
  check_reg(IDX_CYCLE, value + 32'd2);
  debug_mode_i = 1'b1;
  apb_read(12'h000, first, slverr);
  if (slverr !== 1'b0) report_mismatch("pslverr_o", 1'b0, slverr);
  repeat (FREEZE_CYCLES) begin
    take_bits(2 * `PERF_NR_COMMIT_PORTS + 5, bits);
    commit_ack_i      = commit_vec_t'(bits);
    commit_ex_valid_i = commit_vec_t'(bits >> `PERF_NR_COMMIT_PORTS);
    drive_mem_events(bits[2*`PERF_NR_COMMIT_PORTS +: 5]);
    idle_cycles(1);
  end
  commit_ack_i      = '0;
  commit_ex_valid_i = '0;
  drive_mem_events('0);
  apb_read(12'h000, second, slverr);
  if (slverr !== 1'b0) report_mismatch("pslverr_o", 1'b0, slverr);
  if (second !== first) report_mismatch("prdata_o reg 0", first, second);
  for (int unsigned idx = 1; idx < `PERF_NR_REGS; idx++) begin
    check_reg(idx, model_regs[idx]);
  end
endtask

`endif

/* tb/perf_unit_tb.sv */
`default_nettype none

`include "perf_defines.svh"

module perf_unit_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import perf_pkg::*;

  localparam int unsigned CLK_HALF      = 50;
  localparam int unsigned DRIVE_DELAY   = 5;
  localparam int unsigned SAMPLE_DELAY  = 20;
  localparam int unsigned RESET_CYCLES  = 4;
  localparam int unsigned EVENT_CYCLES  = 40;
  localparam int unsigned FREEZE_CYCLES = 10;
  localparam int unsigned MAX_CYCLES    = 2000;
  localparam logic [31:0] LFSR_SEED     = 32'hb6184dca;

  // ----------------------------------------
  // DUT signals
  // ----------------------------------------
  logic        clk_i = 1'b0;
  logic        rst_ni;
  commit_vec_t commit_ack_i;
  commit_vec_t commit_ex_valid_i;
  logic        icache_miss_i;
  logic        dcache_miss_i;
  logic        itlb_miss_i;
  logic        dtlb_miss_i;
  logic        sb_full_i;
  logic        debug_mode_i;
  logic        psel_i;
  logic        penable_i;
  logic        pwrite_i;
  apb_addr_t   paddr_i;
  counter_t    pwdata_i;
  counter_t    prdata_o;
  logic        pready_o;
  logic        pslverr_o;

  // expected register contents, indexed like the register map
  counter_t    model_regs [`PERF_NR_REGS];
  logic [31:0] lfsr_state;
  int          error_count = 0;
  int          cycle_count = 0;

  perf_unit_top DUT (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .commit_ack_i      ( commit_ack_i      ),
    .commit_ex_valid_i ( commit_ex_valid_i ),
    .icache_miss_i     ( icache_miss_i     ),
    .dcache_miss_i     ( dcache_miss_i     ),
    .itlb_miss_i       ( itlb_miss_i       ),
    .dtlb_miss_i       ( dtlb_miss_i       ),
    .sb_full_i         ( sb_full_i         ),
    .debug_mode_i      ( debug_mode_i      ),
    .psel_i            ( psel_i            ),
    .penable_i         ( penable_i         ),
    .pwrite_i          ( pwrite_i          ),
    .paddr_i           ( paddr_i           ),
    .pwdata_i          ( pwdata_i          ),
    .prdata_o          ( prdata_o          ),
    .pready_o          ( pready_o          ),
    .pslverr_o         ( pslverr_o         )
  );

  always #(CLK_HALF) clk_i = ~clk_i;

  // run limit
  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("errors: %0d", error_count);
      $display("TB FAILED");
      $finish;
    end
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  // one LFSR step per bit, newest bit lands in bit 0
  task automatic take_bits(input int unsigned n, output logic [31:0] bits);
    bits = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    error_count++;
  endtask

  // each wait ends DRIVE_DELAY after a rising edge
  task automatic idle_cycles(input int unsigned n);
    repeat (n) begin
      @(posedge clk_i);
      #(DRIVE_DELAY);
    end
  endtask

  `include "perf_tb_tasks.svh"

  initial begin
    lfsr_state        = LFSR_SEED;
    rst_ni            = 1'b0;
    debug_mode_i      = 1'b1;
    commit_ack_i      = '0;
    commit_ex_valid_i = '0;
    icache_miss_i     = 1'b0;
    dcache_miss_i     = 1'b0;
    itlb_miss_i       = 1'b0;
    dtlb_miss_i       = 1'b0;
    sb_full_i         = 1'b0;
    psel_i            = 1'b0;
    penable_i         = 1'b0;
    pwrite_i          = 1'b0;
    paddr_i           = '0;
    pwdata_i          = '0;

    repeat (RESET_CYCLES) @(posedge clk_i);
    #(DRIVE_DELAY);
    rst_ni = 1'b1;
    idle_cycles(1);

    check_reset_state();
    write_and_readback();
    count_retirements();
    count_mem_events();
    cycle_and_freeze();

    $display("errors: %0d", error_count);
    if (error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/perf_apb_regs.sv */
`default_nettype none

`include "perf_defines.svh"

module perf_apb_regs (
  // APB slave
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic                 pwrite_i,
  input  perf_pkg::apb_addr_t  paddr_i,
  input  perf_pkg::counter_t   pwdata_i,
  output perf_pkg::counter_t   prdata_o,
  output logic                 pready_o,
  output logic                 pslverr_o,
  // counter values from both counter blocks
  input  perf_pkg::counter_t   cycle_i,
  input  perf_pkg::counter_t   instret_i,
  input  perf_pkg::counter_t   exception_i,
  input  perf_pkg::counter_t   icache_miss_i,
  input  perf_pkg::counter_t   dcache_miss_i,
  input  perf_pkg::counter_t   itlb_miss_i,
  input  perf_pkg::counter_t   dtlb_miss_i,
  input  perf_pkg::counter_t   sb_full_i,
  // write path to both counter blocks
  output logic                 wr_en_o,
  output perf_pkg::reg_idx_t   wr_idx_o,
  output perf_pkg::counter_t   wr_data_o
);

  import perf_pkg::*;

  logic                             access;
  logic [`PERF_APB_ADDR_WIDTH-3:0]  word_idx;
  logic                             misaligned;
  logic                             out_of_range;
  logic                             addr_err;
  reg_idx_t                         reg_idx;
  counter_t                         rd_sel;

  // ----------------------------------------
  // access phase and address decode
  // ----------------------------------------
  // setup phase is ignored, everything happens in the access cycle
  assign access = psel_i && penable_i;

  assign word_idx     = paddr_i[`PERF_APB_ADDR_WIDTH-1:2];
  assign misaligned   = |paddr_i[1:0];
  assign out_of_range = (word_idx >= `PERF_NR_REGS);
  assign addr_err     = misaligned || out_of_range;
  assign reg_idx      = reg_idx_t'(word_idx[2:0]);

  // zero wait states
  assign pready_o  = access;
  assign pslverr_o = access && addr_err;

  // ----------------------------------------
  // write strobe to the counter blocks
  // ----------------------------------------
  assign wr_en_o   = access && pwrite_i && !addr_err;
  assign wr_idx_o  = reg_idx;
  assign wr_data_o = pwdata_i;

  // ----------------------------------------
  // read multiplexer
  // ----------------------------------------
  always_comb begin
    case (reg_idx)
      IDX_CYCLE:       rd_sel = cycle_i;
      IDX_INSTRET:     rd_sel = instret_i;
      IDX_EXCEPTION:   rd_sel = exception_i;
      IDX_ICACHE_MISS: rd_sel = icache_miss_i;
      IDX_DCACHE_MISS: rd_sel = dcache_miss_i;
      IDX_ITLB_MISS:   rd_sel = itlb_miss_i;
      IDX_DTLB_MISS:   rd_sel = dtlb_miss_i;
      IDX_SB_FULL:     rd_sel = sb_full_i;
      default:         rd_sel = '0;
    endcase
  end

  // read data only in a valid read access, zero otherwise
  assign prdata_o = (access && !pwrite_i && !addr_err) ? rd_sel : '0;

endmodule

`default_nettype wire

/* verilog/perf_defines.svh */
`ifndef PERF_DEFINES_SVH
`define PERF_DEFINES_SVH

// ----------------------------------------
// performance counter unit dimensions
// ----------------------------------------

// width of every counter and of the APB data bus
`define PERF_CNT_WIDTH 32

// commit ports observed per cycle
`define PERF_NR_COMMIT_PORTS 2

// counter registers visible to software
`define PERF_NR_REGS 8

// APB byte address width
`define PERF_APB_ADDR_WIDTH 12

`endif

/* verilog/perf_mem_event_counters.sv */
`default_nettype none

module perf_mem_event_counters (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                debug_mode_i,
  // memory-system events, one cycle high per occurrence
  input  logic                icache_miss_i,
  input  logic                dcache_miss_i,
  input  logic                itlb_miss_i,
  input  logic                dtlb_miss_i,
  input  logic                sb_full_i,
  // software write path
  input  logic                wr_en_i,
  input  perf_pkg::reg_idx_t  wr_idx_i,
  input  perf_pkg::counter_t  wr_data_i,
  // counter values
  output perf_pkg::counter_t  icache_miss_o,
  output perf_pkg::counter_t  dcache_miss_o,
  output perf_pkg::counter_t  itlb_miss_o,
  output perf_pkg::counter_t  dtlb_miss_o,
  output perf_pkg::counter_t  sb_full_o
);

  import perf_pkg::*;

  localparam int unsigned NUM_EVENTS = 5;

  // slot k maps to register index IDX_ICACHE_MISS + k
  logic [NUM_EVENTS-1:0] event_vec;
  counter_t              cnt_q [NUM_EVENTS];
  counter_t              cnt_d [NUM_EVENTS];

  assign event_vec = {sb_full_i, dtlb_miss_i, itlb_miss_i, dcache_miss_i, icache_miss_i};

  // ----------------------------------------
  // next counter values
  // ----------------------------------------
  always_comb begin
    for (int unsigned k = 0; k < NUM_EVENTS; k++) begin
      cnt_d[k] = cnt_q[k];
      if (!debug_mode_i && event_vec[k]) begin
        cnt_d[k] = cnt_q[k] + counter_t'(1);
      end
      // a write to this slot replaces the increment
      if (wr_en_i && (wr_idx_i == reg_idx_t'(IDX_ICACHE_MISS + k))) begin
        cnt_d[k] = wr_data_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned k = 0; k < NUM_EVENTS; k++) begin
        cnt_q[k] <= '0;
      end
    end else begin
      for (int unsigned k = 0; k < NUM_EVENTS; k++) begin
        cnt_q[k] <= cnt_d[k];
      end
    end
  end

  // ----------------------------------------
  // outputs in register map order
  // ----------------------------------------
  assign icache_miss_o = cnt_q[IDX_ICACHE_MISS - IDX_ICACHE_MISS];
  assign dcache_miss_o = cnt_q[IDX_DCACHE_MISS - IDX_ICACHE_MISS];
  assign itlb_miss_o   = cnt_q[IDX_ITLB_MISS - IDX_ICACHE_MISS];
  assign dtlb_miss_o   = cnt_q[IDX_DTLB_MISS - IDX_ICACHE_MISS];
  assign sb_full_o     = cnt_q[IDX_SB_FULL - IDX_ICACHE_MISS];

endmodule

`default_nettype wire

/* verilog/perf_pkg.sv */
`default_nettype none

`include "perf_defines.svh"

package perf_pkg;

  // ----------------------------------------
  // vector types
  // ----------------------------------------
  typedef logic [`PERF_CNT_WIDTH-1:0]       counter_t;
  typedef logic [2:0]                       reg_idx_t;
  typedef logic [`PERF_NR_COMMIT_PORTS-1:0] commit_vec_t;
  typedef logic [`PERF_APB_ADDR_WIDTH-1:0]  apb_addr_t;

  // ----------------------------------------
  // counter register map
  // ----------------------------------------
  // byte address of a register is its index times 4
  localparam reg_idx_t IDX_CYCLE       = 3'd0;
  localparam reg_idx_t IDX_INSTRET     = 3'd1;
  localparam reg_idx_t IDX_EXCEPTION   = 3'd2;
  localparam reg_idx_t IDX_ICACHE_MISS = 3'd3;
  localparam reg_idx_t IDX_DCACHE_MISS = 3'd4;
  localparam reg_idx_t IDX_ITLB_MISS   = 3'd5;
  localparam reg_idx_t IDX_DTLB_MISS   = 3'd6;
  localparam reg_idx_t IDX_SB_FULL     = 3'd7;

endpackage

`default_nettype wire

/* verilog/perf_retire_counters.sv */
`default_nettype none

`include "perf_defines.svh"

module perf_retire_counters (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   debug_mode_i,
  // commit stage status, one flag per port
  input  perf_pkg::commit_vec_t  commit_ack_i,
  input  perf_pkg::commit_vec_t  commit_ex_valid_i,
  // software write path
  input  logic                   wr_en_i,
  input  perf_pkg::reg_idx_t     wr_idx_i,
  input  perf_pkg::counter_t     wr_data_i,
  // counter values
  output perf_pkg::counter_t     cycle_o,
  output perf_pkg::counter_t     instret_o,
  output perf_pkg::counter_t     exception_o
);

  import perf_pkg::*;

  counter_t cycle_q, cycle_d;
  counter_t instret_q, instret_d;
  counter_t exception_q, exception_d;

  counter_t instret_inc;
  counter_t exception_inc;

  // ----------------------------------------
  // per-cycle commit population counts
  // ----------------------------------------
  always_comb begin
    instret_inc   = '0;
    exception_inc = '0;
    for (int unsigned i = 0; i < `PERF_NR_COMMIT_PORTS; i++) begin
      // acked without exception means a retired instruction
      if (commit_ack_i[i] && !commit_ex_valid_i[i]) begin
        instret_inc = instret_inc + counter_t'(1);
      end
      if (commit_ack_i[i] && commit_ex_valid_i[i]) begin
        exception_inc = exception_inc + counter_t'(1);
      end
    end
  end

  // ----------------------------------------
  // next counter values
  // ----------------------------------------
  always_comb begin
    cycle_d     = cycle_q;
    instret_d   = instret_q;
    exception_d = exception_q;

    // counters hold while the core sits in debug mode
    if (!debug_mode_i) begin
      cycle_d     = cycle_q + counter_t'(1);
      instret_d   = instret_q + instret_inc;
      exception_d = exception_q + exception_inc;
    end

    // software write wins over the increment
    if (wr_en_i) begin
      case (wr_idx_i)
        IDX_CYCLE:     cycle_d     = wr_data_i;
        IDX_INSTRET:   instret_d   = wr_data_i;
        IDX_EXCEPTION: exception_d = wr_data_i;
        // memory-event indices belong to the other block
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q     <= '0;
      instret_q   <= '0;
      exception_q <= '0;
    end else begin
      cycle_q     <= cycle_d;
      instret_q   <= instret_d;
      exception_q <= exception_d;
    end
  end

  assign cycle_o     = cycle_q;
  assign instret_o   = instret_q;
  assign exception_o = exception_q;

endmodule

`default_nettype wire

/* verilog/perf_unit_top.sv */
`default_nettype none

module perf_unit_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // events
  input  perf_pkg::commit_vec_t  commit_ack_i,
  input  perf_pkg::commit_vec_t  commit_ex_valid_i,
  input  logic                   icache_miss_i,
  input  logic                   dcache_miss_i,
  input  logic                   itlb_miss_i,
  input  logic                   dtlb_miss_i,
  input  logic                   sb_full_i,
  input  logic                   debug_mode_i,
  // APB slave
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  perf_pkg::apb_addr_t    paddr_i,
  input  perf_pkg::counter_t     pwdata_i,
  output perf_pkg::counter_t     prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o
);

  import perf_pkg::*;

  // ----------------------------------------
  // counter values and write path
  // ----------------------------------------
  counter_t cycle;
  counter_t instret;
  counter_t exception;
  counter_t icache_miss_cnt;
  counter_t dcache_miss_cnt;
  counter_t itlb_miss_cnt;
  counter_t dtlb_miss_cnt;
  counter_t sb_full_cnt;

  logic     wr_en;
  reg_idx_t wr_idx;
  counter_t wr_data;

  perf_retire_counters i_retire_counters (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .debug_mode_i      ( debug_mode_i      ),
    .commit_ack_i      ( commit_ack_i      ),
    .commit_ex_valid_i ( commit_ex_valid_i ),
    .wr_en_i           ( wr_en             ),
    .wr_idx_i          ( wr_idx            ),
    .wr_data_i         ( wr_data           ),
    .cycle_o           ( cycle             ),
    .instret_o         ( instret           ),
    .exception_o       ( exception         )
  );

  perf_mem_event_counters i_mem_event_counters (
    .clk_i         ( clk_i           ),
    .rst_ni        ( rst_ni          ),
    .debug_mode_i  ( debug_mode_i    ),
    .icache_miss_i ( icache_miss_i   ),
    .dcache_miss_i ( dcache_miss_i   ),
    .itlb_miss_i   ( itlb_miss_i     ),
    .dtlb_miss_i   ( dtlb_miss_i     ),
    .sb_full_i     ( sb_full_i       ),
    .wr_en_i       ( wr_en           ),
    .wr_idx_i      ( wr_idx          ),
    .wr_data_i     ( wr_data         ),
    .icache_miss_o ( icache_miss_cnt ),
    .dcache_miss_o ( dcache_miss_cnt ),
    .itlb_miss_o   ( itlb_miss_cnt   ),
    .dtlb_miss_o   ( dtlb_miss_cnt   ),
    .sb_full_o     ( sb_full_cnt     )
  );

  perf_apb_regs i_apb_regs (
    .psel_i        ( psel_i          ),
    .penable_i     ( penable_i       ),
    .pwrite_i      ( pwrite_i        ),
    .paddr_i       ( paddr_i         ),
    .pwdata_i      ( pwdata_i        ),
    .prdata_o      ( prdata_o        ),
    .pready_o      ( pready_o        ),
    .pslverr_o     ( pslverr_o       ),
    .cycle_i       ( cycle           ),
    .instret_i     ( instret         ),
    .exception_i   ( exception       ),
    .icache_miss_i ( icache_miss_cnt ),
    .dcache_miss_i ( dcache_miss_cnt ),
    .itlb_miss_i   ( itlb_miss_cnt   ),
    .dtlb_miss_i   ( dtlb_miss_cnt   ),
    .sb_full_i     ( sb_full_cnt     ),
    .wr_en_o       ( wr_en           ),
    .wr_idx_o      ( wr_idx          ),
    .wr_data_o     ( wr_data         )
  );

endmodule

`default_nettype wire
